// File: rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// register and data path width
`define XLEN 64

// first fetch address
`define RESET_PC 64'h0

// data memory size in bytes, power of two
`define DMEM_BYTES 256

`endif

// File: rvIsaPkg.sv
package rvIsaPkg;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP        = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_32     = 7'b0111011,
        OP_IMM_32 = 7'b0011011,
        LOAD      = 7'b0000011,
        STORE     = 7'b0100011,
        LUI       = 7'b0110111,
        AUIPC     = 7'b0010111,
        JAL       = 7'b1101111,
        JALR      = 7'b1100111,
        BRANCH    = 7'b1100011,
        SYSTEM    = 7'b1110011
    } opcodeT;

    localparam logic [2:0] F3_LB   = 3'h0;
    localparam logic [2:0] F3_LH   = 3'h1;
    localparam logic [2:0] F3_LW   = 3'h2;
    localparam logic [2:0] F3_LD   = 3'h3;
    localparam logic [2:0] F3_LBU  = 3'h4;
    localparam logic [2:0] F3_LHU  = 3'h5;

    localparam logic [2:0] F3_SB   = 3'h0;
    localparam logic [2:0] F3_SH   = 3'h1;
    localparam logic [2:0] F3_SW   = 3'h2;
    localparam logic [2:0] F3_SD   = 3'h3;

    localparam logic [2:0] F3_BEQ  = 3'h0;
    localparam logic [2:0] F3_BNE  = 3'h1;
    localparam logic [2:0] F3_BLT  = 3'h4;
    localparam logic [2:0] F3_BGE  = 3'h5;
    localparam logic [2:0] F3_BLTU = 3'h6;
    localparam logic [2:0] F3_BGEU = 3'h7;

    localparam logic [6:0] F7_BASE   = 7'h00;
    localparam logic [6:0] F7_ALT    = 7'h20; // sub
    localparam logic [6:0] F7_MULDIV = 7'h01; // M extension

endpackage

// File: rvCtrlPkg.sv
package rvCtrlPkg;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        MUL,    // low XLEN bits of product
        XOR,
        OR,
        AND,
        SLL,
        SRL,
        SLT,
        SLTU,
        PASS_B, // lui
        NONE
    } aluOpT;

    // write-back source
    typedef enum logic [1:0] {
        ALU,
        MEM,
        PC_PLUS4,
        ALU_W   // low word, sign-extended
    } wbSelT;

endpackage

// File: rvAlu.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rvAlu (
    input  rvCtrlPkg::aluOpT  aluOp,
    input  logic [`XLEN-1:0]  a,
    input  logic [`XLEN-1:0]  b,
    output logic [`XLEN-1:0]  result
);
    import rvCtrlPkg::*;

    logic [$clog2(`XLEN)-1:0] shamt;
    logic                     lessSigned;
    logic                     lessUnsigned;

    assign shamt        = b[$clog2(`XLEN)-1:0]; // low 6 bits
    assign lessSigned   = $signed(a) < $signed(b);
    assign lessUnsigned = a < b;

    always_comb begin
        case (aluOp)
            ADD:     result = a + b;
            SUB:     result = a - b;
            MUL:     result = a * b; // truncated product
            XOR:     result = a ^ b;
            OR:      result = a | b;
            AND:     result = a & b;
            SLL:     result = a << shamt;
            SRL:     result = a >> shamt;
            SLT:     result = {{(`XLEN-1){1'b0}}, lessSigned};
            SLTU:    result = {{(`XLEN-1){1'b0}}, lessUnsigned};
            PASS_B:  result = b;
            default: result = '0;
        endcase
    end

endmodule

// File: rvImmGen.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rvImmGen (
    input  logic [31:0]      inst,
    output logic [`XLEN-1:0] imm
);
    import rvIsaPkg::*;

    always_comb begin
        case (inst[6:0])
            OP_IMM, OP_IMM_32, LOAD, JALR, SYSTEM: begin
                imm = {{(`XLEN-12){inst[31]}}, inst[31:20]};
            end
            STORE: begin
                imm = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
            end
            BRANCH: begin
                imm = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                       inst[11:8], 1'b0};
            end
            LUI, AUIPC: begin
                imm = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
            end
            JAL: begin
                imm = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                       inst[30:21], 1'b0};
            end
            default: imm = '0; // register-register forms
        endcase
    end

endmodule

// File: rvDecoder.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rvDecoder (
    input  logic [31:0]       inst,
    input  logic [`XLEN-1:0]  rs1Data,
    input  logic [`XLEN-1:0]  rs2Data,
    output rvCtrlPkg::aluOpT  aluOp,
    output logic              selA,     // 1: rs1, 0: pc
    output logic              selB,     // 1: rs2, 0: imm
    output logic              regWrite,
    output logic              memRead,
    output logic              loadSigned,
    output logic              jump,
    output logic              jumpReg,
    output logic              halt,
    output rvCtrlPkg::wbSelT  wbSel,
    output logic [3:0]        loadBytes,
    output logic [7:0]        storeMask
);
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    opcodeT     opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       signedLt;
    logic       unsignedLt;

    assign opcode     = opcodeT'(inst[6:0]);
    assign funct3     = inst[14:12];
    assign funct7     = inst[31:25];
    assign signedLt   = $signed(rs1Data) < $signed(rs2Data);
    assign unsignedLt = rs1Data < rs2Data;

    // funct3 map shared by OP and OP-IMM
    function automatic aluOpT baseOp(input logic [2:0] f3, input logic plainShift);
        case (f3)
            3'b000:  return ADD;
            3'b001:  return plainShift ? SLL : NONE;
            3'b010:  return SLT;
            3'b011:  return SLTU;
            3'b100:  return XOR;
            3'b101:  return plainShift ? SRL : NONE; // no sra
            3'b110:  return OR;
            default: return AND;
        endcase
    endfunction

    always_comb begin
        aluOp      = NONE;
        selA       = 1'b1;
        selB       = 1'b1;
        regWrite   = 1'b0;
        memRead    = 1'b0;
        loadSigned = 1'b0;
        loadBytes  = 4'd0;
        storeMask  = 8'h00;
        wbSel      = ALU;
        jump       = 1'b0;
        jumpReg    = 1'b0;
        halt       = 1'b0;
        case (opcode)
            OP: begin
                regWrite = 1'b1;
                case (funct7)
                    F7_BASE:   aluOp = baseOp(funct3, 1'b1);
                    F7_ALT:    aluOp = (funct3 == 3'b000) ? SUB : NONE;
                    F7_MULDIV: aluOp = (funct3 == 3'b000) ? MUL : NONE; // div/rem dropped
                    default:   aluOp = NONE;
                endcase
            end
            OP_IMM: begin
                selB     = 1'b0;
                regWrite = 1'b1;
                aluOp    = baseOp(funct3, inst[31:26] == 6'b0);
            end
            OP_32: begin
                regWrite = 1'b1;
                wbSel    = ALU_W;
                if (funct3 == 3'b000 && funct7 == F7_BASE) begin
                    aluOp = ADD;
                end else if (funct3 == 3'b000 && funct7 == F7_MULDIV) begin
                    aluOp = MUL;
                end
            end
            OP_IMM_32: begin
                selB     = 1'b0;
                regWrite = 1'b1;
                wbSel    = ALU_W;
                aluOp    = (funct3 == 3'b000) ? ADD : NONE; // addiw only
            end
            LUI: begin
                selB     = 1'b0;
                regWrite = 1'b1;
                aluOp    = PASS_B;
            end
            AUIPC: begin
                selA     = 1'b0;
                selB     = 1'b0;
                regWrite = 1'b1;
                aluOp    = ADD;
            end
            LOAD: begin
                selB     = 1'b0;
                aluOp    = ADD;
                regWrite = 1'b1;
                memRead  = 1'b1;
                wbSel    = MEM;
                case (funct3)
                    F3_LB:  begin loadBytes = 4'd1; loadSigned = 1'b1; end
                    F3_LH:  begin loadBytes = 4'd2; loadSigned = 1'b1; end
                    F3_LW:  begin loadBytes = 4'd4; loadSigned = 1'b1; end
                    F3_LD:  loadBytes = 4'd8;
                    F3_LBU: loadBytes = 4'd1;
                    F3_LHU: loadBytes = 4'd2;
                    default: begin
                        regWrite = 1'b0;
                        memRead  = 1'b0;
                    end
                endcase
            end
            STORE: begin
                selB  = 1'b0;
                aluOp = ADD;
                case (funct3)
                    F3_SB:   storeMask = 8'h01;
                    F3_SH:   storeMask = 8'h03;
                    F3_SW:   storeMask = 8'h0f;
                    F3_SD:   storeMask = 8'hff;
                    default: storeMask = 8'h00;
                endcase
            end
            JAL: begin
                regWrite = 1'b1;
                wbSel    = PC_PLUS4;
                jump     = 1'b1;
            end
            JALR: begin
                regWrite = 1'b1;
                wbSel    = PC_PLUS4;
                jump     = 1'b1;
                jumpReg  = 1'b1;
            end
            BRANCH: begin
                case (funct3)
                    F3_BEQ:  jump = rs1Data == rs2Data;
                    F3_BNE:  jump = rs1Data != rs2Data;
                    F3_BLT:  jump = signedLt;
                    F3_BGE:  jump = !signedLt;
                    F3_BLTU: jump = unsignedLt;
                    F3_BGEU: jump = !unsignedLt;
                    default: jump = 1'b0;
                endcase
            end
            SYSTEM: begin
                halt = (funct3 == 3'b000) && (inst[31:20] == 12'h001); // ebreak
            end
            default: ;
        endcase
    end

endmodule

// File: rvRegFile.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rvRegFile (
    input  logic             clk,
    input  logic             rst,
    input  logic [4:0]       rs1Addr,
    input  logic [4:0]       rs2Addr,
    input  logic [4:0]       rdAddr,
    input  logic             writeEn,
    input  logic [`XLEN-1:0] rdData,
    output logic [`XLEN-1:0] rs1Data,
    output logic [`XLEN-1:0] rs2Data
);
    logic [`XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && rdAddr != 5'd0) begin
            regs[rdAddr] <= rdData;
        end
    end

    // x0 reads as zero
    assign rs1Data = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

endmodule

// File: rvLoadStore.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rvLoadStore (
    input  logic             clk,
    input  logic [`XLEN-1:0] addr,
    input  logic [`XLEN-1:0] writeData,
    input  logic [7:0]       storeMask,
    input  logic [3:0]       loadBytes,
    input  logic             loadSigned,
    output logic [`XLEN-1:0] readData
);
    localparam int AW = $clog2(`DMEM_BYTES);

    logic [7:0]       mem [`DMEM_BYTES];
    logic [AW-1:0]    base;
    logic [`XLEN-1:0] raw;
    logic             signBit;

    assign base = addr[AW-1:0]; // wraps inside the array

    always_ff @(posedge clk) begin
        for (int i = 0; i < 8; i++) begin
            if (storeMask[i]) begin
                mem[base + AW'(i)] <= writeData[8*i +: 8];
            end
        end
    end

    always_comb begin
        raw = '0;
        for (int i = 0; i < 8; i++) begin
            if (i < loadBytes) begin
                raw[8*i +: 8] = mem[base + AW'(i)]; // little-endian
            end
        end
        case (loadBytes)
            4'd1:    signBit = raw[7];
            4'd2:    signBit = raw[15];
            4'd4:    signBit = raw[31];
            default: signBit = raw[`XLEN-1];
        endcase
        readData = raw;
        for (int i = 0; i < 8; i++) begin
            if (loadSigned && i >= loadBytes) begin
                readData[8*i +: 8] = {8{signBit}};
            end
        end
    end

endmodule

// File: rvCore.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rvCore (
    input  logic             clk,
    input  logic             rst,
    input  logic [31:0]      inst,
    output logic [`XLEN-1:0] pc,
    output logic             wbEn,
    output logic [4:0]       wbRd,
    output logic [`XLEN-1:0] wbData,
    output logic             halted
);
    import rvCtrlPkg::*;

    aluOpT            aluOp;
    wbSelT            wbSel;
    logic             selA, selB, regWrite, memRead, loadSigned;
    logic             jump, jumpReg, halt, commitEn;
    logic [3:0]       loadBytes, readBytes;
    logic [7:0]       storeMask, memMask;
    logic [`XLEN-1:0] imm, rs1Data, rs2Data, opA, opB;
    logic [`XLEN-1:0] aluResult, memData, pcPlus4, jalrTarget, nextPc;

    rvDecoder rvDecoder_inst (
        .inst(inst), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .aluOp(aluOp), .selA(selA), .selB(selB), .regWrite(regWrite),
        .memRead(memRead), .loadSigned(loadSigned), .jump(jump), .jumpReg(jumpReg),
        .halt(halt), .wbSel(wbSel), .loadBytes(loadBytes), .storeMask(storeMask)
    );

    rvImmGen rvImmGen_inst (.inst(inst), .imm(imm));

    rvRegFile rvRegFile_inst (
        .clk(clk), .rst(rst), .rs1Addr(inst[19:15]), .rs2Addr(inst[24:20]),
        .rdAddr(wbRd), .writeEn(wbEn), .rdData(wbData),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    assign opA = selA ? rs1Data : pc;
    assign opB = selB ? rs2Data : imm;

    rvAlu rvAlu_inst (.aluOp(aluOp), .a(opA), .b(opB), .result(aluResult));

    assign commitEn  = !rst && !halted;
    assign memMask   = commitEn ? storeMask : 8'h00;
    assign readBytes = memRead ? loadBytes : 4'd0; // non-loads read zero

    rvLoadStore rvLoadStore_inst (
        .clk(clk), .addr(aluResult), .writeData(rs2Data), .storeMask(memMask),
        .loadBytes(readBytes), .loadSigned(loadSigned), .readData(memData)
    );

    always_comb begin
        case (wbSel)
            MEM:      wbData = memData;
            PC_PLUS4: wbData = pcPlus4;
            ALU_W:    wbData = {{(`XLEN-32){aluResult[31]}}, aluResult[31:0]};
            default:  wbData = aluResult;
        endcase
    end

    assign wbRd = inst[11:7];
    assign wbEn = regWrite && commitEn && wbRd != 5'd0;

    assign pcPlus4    = pc + `XLEN'(4);
    assign jalrTarget = rs1Data + imm;
    assign nextPc     = !jump   ? pcPlus4 :
                        jumpReg ? {jalrTarget[`XLEN-1:1], 1'b0} : pc + imm;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc     <= `RESET_PC;
            halted <= 1'b0;
        end else if (!halted) begin
            halted <= halt;
            if (!halt) begin
                pc <= nextPc; // pc stays on the ebreak
            end
        end
    end

endmodule

// File: rvCore_assertions.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rvCoreAssertions (
    input logic             clk,
    input logic             rst,
    input logic [`XLEN-1:0] pc,
    input logic             wbEn,
    input logic [4:0]       wbRd,
    input logic             halted
);

    noWriteInReset: assert property (@(posedge clk) rst |-> !wbEn)
        else $error("wbEn high while rst is high");

    // x0 writes are never exported
    noWriteToX0: assert property (@(posedge clk) wbEn |-> wbRd != 5'd0)
        else $error("wbEn high with wbRd zero");

    pcFrozen: assert property (@(posedge clk) disable iff (rst) halted |=> $stable(pc))
        else $error("pc changed after halt");

endmodule

// File: tb_rvCore.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module tb_rvCore;
    import rvIsaPkg::*;

    typedef struct packed {
        logic [31:0]      ins;
        logic             en;
        logic [4:0]       rd;
        logic [`XLEN-1:0] data;
        int               next; // row index fetched after this one
    } rowT;

    logic             clk;
    logic             rst;
    logic [31:0]      inst;
    logic [`XLEN-1:0] pc;
    logic             wbEn;
    logic [4:0]       wbRd;
    logic [`XLEN-1:0] wbData;
    logic             halted;

    rowT  rows[$];
    int   haltIdx;
    int   errCount = 0;
    logic tableReady = 1'b0;

    rvCore rvCore_inst (
        .clk(clk), .rst(rst), .inst(inst), .pc(pc), .wbEn(wbEn),
        .wbRd(wbRd), .wbData(wbData), .halted(halted)
    );

    bind rvCore rvCoreAssertions rvCoreAssertions_inst (
        .clk(clk), .rst(rst), .pc(pc), .wbEn(wbEn), .wbRd(wbRd), .halted(halted)
    );

    function automatic logic [31:0] rFormat(input int f7, input int rs2, input int rs1,
                                            input int f3, input int rd, input opcodeT op);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] iFormat(input int imm, input int rs1, input int f3,
                                            input int rd, input opcodeT op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] sFormat(input int imm, input int rs2, input int rs1,
                                            input int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], STORE};
    endfunction

    function automatic logic [31:0] bFormat(input int off, input int rs1, input int rs2,
                                            input int f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], BRANCH};
    endfunction

    function automatic logic [31:0] uFormat(input int imm, input int rd, input opcodeT op);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] jFormat(input int off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], JAL};
    endfunction

    task automatic addRow(input logic [31:0] ins, input int en, input int rd,
                          input logic [`XLEN-1:0] data, input int step = 1);
        rowT r;
        r.ins  = ins;
        r.en   = (en != 0);
        r.rd   = rd[4:0];
        r.data = data;
        r.next = rows.size() + step;
        rows.push_back(r);
    endtask

    task automatic buildTable();
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] val;
        logic [31:0]      r;
        int               hi;
        int               lo;
        int               brF3[6]    = '{0, 1, 4, 5, 6, 7}; // beq bne blt bge bltu bgeu
        int               takenA[6]  = '{1, 1, 2, 1, 1, 2};
        int               takenB[6]  = '{1, 2, 1, 2, 2, 1};
        int               untakenA[6] = '{1, 1, 1, 2, 2, 1};
        int               untakenB[6] = '{2, 1, 2, 1, 1, 2};
        a = 64'd100;
        b = -64'd7;
        addRow(iFormat(100, 0, 0, 1, OP_IMM), 1, 1, a);
        addRow(iFormat(-7, 0, 0, 2, OP_IMM), 1, 2, b);
        addRow(rFormat(0, 2, 1, 0, 3, OP), 1, 3, a + b);
        addRow(rFormat(32, 1, 2, 0, 4, OP), 1, 4, b - a);
        addRow(rFormat(0, 2, 1, 4, 5, OP), 1, 5, a ^ b);
        addRow(rFormat(0, 2, 1, 6, 6, OP), 1, 6, a | b);
        addRow(rFormat(0, 2, 1, 7, 7, OP), 1, 7, a & b);
        addRow(rFormat(0, 3, 1, 1, 8, OP), 1, 8, a << 29);  // 93 mod 64
        addRow(rFormat(0, 1, 2, 5, 9, OP), 1, 9, b >> 36);  // 100 mod 64
        addRow(rFormat(0, 1, 2, 2, 10, OP), 1, 10, 64'd1);
        addRow(rFormat(0, 1, 2, 3, 11, OP), 1, 11, 64'd0);
        addRow(rFormat(1, 2, 1, 0, 12, OP), 1, 12, a * b);
        addRow(iFormat(40, 1, 1, 13, OP_IMM), 1, 13, a << 40);
        addRow(iFormat(-1, 1, 3, 14, OP_IMM), 1, 14, 64'd1);
        addRow(iFormat(5, 1, 0, 0, OP_IMM), 0, 0, '0); // rd x0, no write
        addRow(uFormat(32'h80000, 20, LUI), 1, 20, 64'hFFFFFFFF_80000000);
        addRow(uFormat(1, 21, AUIPC), 1, 21, 64'(rows.size() * 4) + 64'h1000);
        addRow(iFormat(-1, 20, 0, 22, OP_IMM_32), 1, 22, 64'h7FFFFFFF);
        addRow(rFormat(0, 1, 22, 0, 23, OP_32), 1, 23, 64'hFFFFFFFF_80000063);
        addRow(rFormat(1, 1, 22, 0, 24, OP_32), 1, 24, -64'd100); // low word 0xffffff9c
        // random store data from lui + addi
        r   = $urandom;
        hi  = r >> 12;
        lo  = r & 32'hFFF;
        val = {{32{r[31]}}, r[31:12], 12'h000} + {{52{r[11]}}, r[11:0]};
        addRow(uFormat(hi, 25, LUI), 1, 25, {{32{r[31]}}, r[31:12], 12'h000});
        addRow(iFormat(lo, 25, 0, 25, OP_IMM), 1, 25, val);
        addRow(sFormat(64, 25, 0, 3), 0, 0, '0);
        addRow(iFormat(64, 0, 3, 26, LOAD), 1, 26, val);
        addRow(iFormat(68, 0, 2, 27, LOAD), 1, 27, {{32{val[63]}}, val[63:32]});
        addRow(iFormat(66, 0, 1, 28, LOAD), 1, 28, {{48{val[31]}}, val[31:16]});
        addRow(iFormat(65, 0, 0, 29, LOAD), 1, 29, {{56{val[15]}}, val[15:8]});
        addRow(iFormat(64, 0, 5, 30, LOAD), 1, 30, {48'h0, val[15:0]});
        addRow(iFormat(64, 0, 4, 31, LOAD), 1, 31, {56'h0, val[7:0]});
        for (int k = 0; k < 6; k++) begin
            addRow(bFormat(8, untakenA[k], untakenB[k], brF3[k]), 0, 0, '0);
            addRow(bFormat(8, takenA[k], takenB[k], brF3[k]), 0, 0, '0, 2);
            addRow(iFormat(1, 0, 0, 3, OP_IMM), 1, 3, 64'd1); // jumped over
        end
        addRow(jFormat(8, 5), 1, 5, 64'(rows.size() * 4 + 4), 2);
        addRow(iFormat(1, 0, 0, 3, OP_IMM), 1, 3, 64'd1);
        // odd target, bit 0 must be dropped
        addRow(iFormat(rows.size() * 4 + 9, 0, 0, 6, JALR), 1, 6,
               64'(rows.size() * 4 + 4), 2);
        addRow(iFormat(1, 0, 0, 3, OP_IMM), 1, 3, 64'd1);
        haltIdx = rows.size();
        addRow(iFormat(1, 0, 0, 0, SYSTEM), 0, 0, '0, 0); // ebreak
        addRow(iFormat(5, 0, 0, 1, OP_IMM), 0, 0, '0);
        addRow(sFormat(64, 1, 0, 3), 0, 0, '0);
    endtask

    task automatic checkValue(input string name, input logic [`XLEN-1:0] got,
                              input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            errCount++;
            $display("ERR t=%0t %s: got %h, expected %h", $time, name, got, exp);
            $display("Done: errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    // drive one row in the low clock phase and check the retiring write
    task automatic runRow(input int k, input logic [`XLEN-1:0] expPc);
        checkValue("pc", pc, expPc);
        inst = rows[k].ins;
        #2;
        checkValue("wbEn", 64'(wbEn), 64'(rows[k].en));
        if (rows[k].en) begin
            checkValue("wbRd", 64'(wbRd), 64'(rows[k].rd));
            checkValue("wbData", wbData, rows[k].data);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        wait (tableReady);
        #((rows.size() + 10) * 10);
        $display("watchdog expired: the program did not reach its end in time");
        $display("Done: errors found");
        $fatal(1, "timeout");
    end

    initial begin
        int idx;
        rst  = 1'b1;
        inst = iFormat(0, 0, 0, 1, OP_IMM); // addi x1, x0, 0 held through reset
        void'($urandom(12892));
        buildTable();
        tableReady = 1'b1;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        idx = 0;
        while (idx != haltIdx) begin
            runRow(idx, 64'(idx * 4));
            idx = rows[idx].next;
            @(negedge clk);
        end
        runRow(haltIdx, 64'(haltIdx * 4));
        @(negedge clk);
        for (int k = haltIdx + 1; k < rows.size(); k++) begin
            checkValue("halted", 64'(halted), 64'd1);
            runRow(k, 64'(haltIdx * 4)); // pc stays on the ebreak
            @(negedge clk);
        end
        if (errCount != 0) begin
            $display("Done: errors found");
            $fatal(1, "checks failed");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

// File: verilog.f
+incdir+.
rvIsaPkg.sv
rvCtrlPkg.sv
rvAlu.sv
rvImmGen.sv
rvDecoder.sv
rvRegFile.sv
rvLoadStore.sv
rvCore.sv
rvCore_assertions.sv
tb_rvCore.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_rvCore -f verilog.f \
    -o simv && ./obj_dir/simv > sim.log 2>&1 || echo "Done: errors found" >> sim.log
cat sim.log
if grep -q "Done: errors found" sim.log; then
    exit 1
fi
exit 0
